//--- verilog/rename_pkg.sv
package rename_pkg;

    parameter int arch_regs = 32;
    parameter int phys_regs = 64;
    parameter int xlen = 32;

    parameter int arch_idx_w = $clog2(arch_regs);
    parameter int phys_idx_w = $clog2(phys_regs);

    typedef logic [arch_idx_w-1:0] arch_idx_t;
    typedef logic [phys_idx_w-1:0] phys_idx_t;

    // one micro-op as seen by the renamer
    typedef struct packed {
        arch_idx_t rd1;
        arch_idx_t rd2;
        arch_idx_t wr;
    } rename_req_t;

    // retirement from the reorder buffer
    typedef struct packed {
        arch_idx_t arch;
        phys_idx_t nonspec_phys;
        phys_idx_t free_phys;
    } commit_t;

    // one result from the writeback ring
    typedef struct packed {
        phys_idx_t        phys;
        logic [xlen-1:0]  val;
    } wb_t;

    typedef struct packed {
        phys_idx_t        rd1;
        phys_idx_t        rd2;
        phys_idx_t        wr;
        phys_idx_t        oldwr;
        logic [xlen-1:0]  rd1_val;
        logic [xlen-1:0]  rd2_val;
        logic             rd1_rdy;
        logic             rd2_rdy;
    } rename_resp_t;

endpackage

//--- verilog/arch_regfile.sv
`timescale 1ns/1ns

module arch_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      uop_update,
    input  rename_pkg::rename_req_t   req,
    input  rename_pkg::phys_idx_t     new_phys,
    input  logic                      rob_update,
    input  rename_pkg::commit_t       commit,
    input  logic                      rollback,
    output rename_pkg::rename_resp_t  lookup
);

    // speculative map, written at rename time
    rename_pkg::phys_idx_t spec_map [rename_pkg::arch_regs];
    // committed map, written at retirement
    rename_pkg::phys_idx_t comm_map [rename_pkg::arch_regs];
    rename_pkg::phys_idx_t comm_next [rename_pkg::arch_regs];

    // commit lands before a rollback reads the committed copy
    always_comb begin
        comm_next = comm_map;
        if (rob_update) begin
            comm_next[commit.arch] = commit.nonspec_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                comm_map[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else begin
            comm_map <= comm_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                spec_map[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else if (rollback) begin
            spec_map <= comm_next;
        end else if (uop_update) begin
            spec_map[req.wr] <= new_phys;
        end
    end

    // lookups see the map before this cycle's write
    always_ff @(posedge clk) begin
        if (uop_update) begin
            lookup       <= '0;
            lookup.rd1   <= spec_map[req.rd1];
            lookup.rd2   <= spec_map[req.rd2];
            lookup.oldwr <= spec_map[req.wr];
            lookup.wr    <= new_phys;
        end
    end

    // a flush and a new micro-op never share a cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(uop_update && rollback))
        else $error("uop_update asserted together with rollback");

endmodule

//--- verilog/free_list.sv
`timescale 1ns/1ns

module free_list (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  logic                   rob_update,
    input  rename_pkg::phys_idx_t  commit_free,
    input  rename_pkg::phys_idx_t  commit_use,
    input  logic                   rollback,
    output rename_pkg::phys_idx_t  next_free,
    output logic                   none_free
);

    localparam int spare = rename_pkg::phys_regs - rename_pkg::arch_regs;

    // identity mapping owns the low registers after reset
    localparam logic [rename_pkg::phys_regs-1:0] reset_free =
        {{spare{1'b1}}, {rename_pkg::arch_regs{1'b0}}};

    logic [rename_pkg::phys_regs-1:0] spec_free;
    logic [rename_pkg::phys_regs-1:0] comm_free;
    logic [rename_pkg::phys_regs-1:0] comm_next;
    logic [rename_pkg::phys_regs-1:0] spec_next;

    // lowest set bit wins
    always_comb begin
        next_free = '0;
        for (int i = rename_pkg::phys_regs - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                next_free = rename_pkg::phys_idx_t'(i);
            end
        end
    end

    assign none_free = ~|spec_free;

    always_comb begin
        comm_next = comm_free;
        spec_next = spec_free;
        if (rob_update) begin
            comm_next[commit_use]  = 1'b0;
            comm_next[commit_free] = 1'b1;
            spec_next[commit_free] = 1'b1;
        end
        if (alloc) begin
            spec_next[next_free] = 1'b0;
        end
        // rollback takes the committed vector including this cycle's commit
        if (rollback) begin
            spec_next = comm_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spec_free <= reset_free;
            comm_free <= reset_free;
        end else begin
            spec_free <= spec_next;
            comm_free <= comm_next;
        end
    end

    // the front end must stall on none_free
    assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !none_free)
        else $error("allocation with no free physical register");

endmodule

//--- verilog/phys_file.sv
`timescale 1ns/1ns

module phys_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          alloc,
    input  rename_pkg::phys_idx_t         alloc_idx,
    input  logic                          wb_update,
    input  rename_pkg::wb_t               wb,
    input  rename_pkg::phys_idx_t         rd1,
    input  rename_pkg::phys_idx_t         rd2,
    output logic [rename_pkg::xlen-1:0]   rd1_val,
    output logic [rename_pkg::xlen-1:0]   rd2_val,
    output logic                          rd1_rdy,
    output logic                          rd2_rdy
);

    localparam int spare = rename_pkg::phys_regs - rename_pkg::arch_regs;

    logic [rename_pkg::xlen-1:0] vals [rename_pkg::phys_regs];
    logic [rename_pkg::phys_regs-1:0] ready;

    // architectural state starts as zero in the low registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::phys_regs; i++) begin
                vals[i] <= '0;
            end
        end else if (wb_update) begin
            vals[wb.phys] <= wb.val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= {{spare{1'b0}}, {rename_pkg::arch_regs{1'b1}}};
        end else begin
            if (alloc) begin
                ready[alloc_idx] <= 1'b0;
            end
            // ring result marks it ready again
            if (wb_update) begin
                ready[wb.phys] <= 1'b1;
            end
        end
    end

    // no bypass, a same-cycle ring write is missed
    always_ff @(posedge clk) begin
        rd1_val <= vals[rd1];
        rd2_val <= vals[rd2];
        rd1_rdy <= ready[rd1];
        rd2_rdy <= ready[rd2];
    end

    // only renamed, still pending registers get a result
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_update |-> !ready[wb.phys])
        else $error("writeback to a register that is already ready");

endmodule

//--- verilog/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          uop_update,
    input  rename_pkg::phys_idx_t         rd1,
    input  rename_pkg::phys_idx_t         rd2,
    input  logic                          wb_update,
    input  rename_pkg::wb_t               wb,
    input  logic                          rob_update,
    input  rename_pkg::phys_idx_t         commit_free,
    input  rename_pkg::phys_idx_t         commit_use,
    input  logic                          rollback,
    output rename_pkg::phys_idx_t         next_free,
    output logic                          none_free,
    output logic [rename_pkg::xlen-1:0]   rd1_val,
    output logic [rename_pkg::xlen-1:0]   rd2_val,
    output logic                          rd1_rdy,
    output logic                          rd2_rdy
);

    logic                   alloc_q;
    rename_pkg::phys_idx_t  alloc_idx_q;

    // allocated index follows the micro-op into the read stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_q <= 1'b0;
        end else begin
            alloc_q <= uop_update;
        end
    end

    always_ff @(posedge clk) begin
        alloc_idx_q <= next_free;
    end

    free_list u_free_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (uop_update),
        .rob_update  (rob_update),
        .commit_free (commit_free),
        .commit_use  (commit_use),
        .rollback    (rollback),
        .next_free   (next_free),
        .none_free   (none_free)
    );

    phys_file u_phys_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc_q),
        .alloc_idx (alloc_idx_q),
        .wb_update (wb_update),
        .wb        (wb),
        .rd1       (rd1),
        .rd2       (rd2),
        .rd1_val   (rd1_val),
        .rd2_val   (rd2_val),
        .rd1_rdy   (rd1_rdy),
        .rd2_rdy   (rd2_rdy)
    );

endmodule

//--- verilog/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      uop_update,
    input  rename_pkg::rename_req_t   req,
    input  logic                      wb_update,
    input  rename_pkg::wb_t           wb,
    input  logic                      rob_update,
    input  rename_pkg::commit_t       commit,
    input  logic                      rollback,
    output logic                      resp_valid,
    output rename_pkg::rename_resp_t  resp,
    output logic                      none_free
);

    rename_pkg::rename_resp_t     lookup;
    rename_pkg::phys_idx_t        next_free;
    logic [rename_pkg::xlen-1:0]  rd1_val;
    logic [rename_pkg::xlen-1:0]  rd2_val;
    logic                         rd1_rdy;
    logic                         rd2_rdy;
    logic                         s1_valid;
    rename_pkg::phys_idx_t        rd1_q;
    rename_pkg::phys_idx_t        rd2_q;
    rename_pkg::phys_idx_t        wr_q;
    rename_pkg::phys_idx_t        oldwr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            s1_valid   <= uop_update;
            resp_valid <= s1_valid;
        end
    end

    // stage 2 index registers, values come from phys_file
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rd1_q   <= lookup.rd1;
            rd2_q   <= lookup.rd2;
            wr_q    <= lookup.wr;
            oldwr_q <= lookup.oldwr;
        end
    end

    always_comb begin
        resp.rd1     = rd1_q;
        resp.rd2     = rd2_q;
        resp.wr      = wr_q;
        resp.oldwr   = oldwr_q;
        resp.rd1_val = rd1_val;
        resp.rd2_val = rd2_val;
        resp.rd1_rdy = rd1_rdy;
        resp.rd2_rdy = rd2_rdy;
    end

    arch_regfile u_arch_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_update (uop_update),
        .req        (req),
        .new_phys   (next_free),
        .rob_update (rob_update),
        .commit     (commit),
        .rollback   (rollback),
        .lookup     (lookup)
    );

    phys_regfile u_phys_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop_update  (uop_update),
        .rd1         (lookup.rd1),
        .rd2         (lookup.rd2),
        .wb_update   (wb_update),
        .wb          (wb),
        .rob_update  (rob_update),
        .commit_free (commit.free_phys),
        .commit_use  (commit.nonspec_phys),
        .rollback    (rollback),
        .next_free   (next_free),
        .none_free   (none_free),
        .rd1_val     (rd1_val),
        .rd2_val     (rd2_val),
        .rd1_rdy     (rd1_rdy),
        .rd2_rdy     (rd2_rdy)
    );

endmodule

//--- sim/tb_rename_regfile.sv
`timescale 1ns/1ns

module tb_rename_regfile;

    localparam int max_cases = 128;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      uop_update;
    rename_pkg::rename_req_t   req;
    logic                      wb_update;
    rename_pkg::wb_t           wb;
    logic                      rob_update;
    rename_pkg::commit_t       commit;
    logic                      rollback;
    logic                      resp_valid;
    rename_pkg::rename_resp_t  resp;
    logic                      none_free;

    // one operation letter and up to eleven operands per case
    logic [7:0]   case_op [max_cases];
    logic [31:0]  case_arg [max_cases][11];
    int           num_cases = 0;
    int           pass_count = 0;
    int           fail_count = 0;
    int           cycles = 0;
    int           limit = 50;
    int           tick = 0;
    int           due_case [$];
    int           due_tick [$];

    rename_regfile u_rename_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_update (uop_update),
        .req        (req),
        .wb_update  (wb_update),
        .wb         (wb),
        .rob_update (rob_update),
        .commit     (commit),
        .rollback   (rollback),
        .resp_valid (resp_valid),
        .resp       (resp),
        .none_free  (none_free)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic load_cases();
        int               fd;
        int               code;
        logic [7:0]       op;
        logic [8*128-1:0] rest;
        logic [31:0]      f [11];
        fd = $fopen("sim/rename_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/rename_cases.txt");
        end else begin
            while (!$feof(fd) && num_cases < max_cases) begin
                f = '{default: '0};
                code = $fscanf(fd, " %c", op);
                if (code == 1 && (op == "R" || op == "W" || op == "C" || op == "B"
                                  || op == "N")) begin
                    case (op)
                        "R": code = $fscanf(fd, "%d %d %d %d %d %d %d %h %h %d %d",
                                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                            f[7], f[8], f[9], f[10]);
                        "W": code = $fscanf(fd, "%d %h", f[0], f[1]);
                        "C": code = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
                        "B": code = $fscanf(fd, "%d %d %d %d", f[0], f[1], f[2], f[3]);
                        default: code = $fscanf(fd, "%d", f[0]);
                    endcase
                    case_op[num_cases] = op;
                    case_arg[num_cases] = f;
                    num_cases++;
                end else if (code == 1) begin
                    if (op != "#") begin
                        $display("unknown operation %c in case file", op);
                        fail_count++;
                    end
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
        if (num_cases == 0) begin
            $display("no cases were read from the case file");
            fail_count++;
        end
    endtask

    task automatic drive_idle();
        uop_update = 1'b0;
        req        = '0;
        wb_update  = 1'b0;
        wb         = '0;
        rob_update = 1'b0;
        commit     = '0;
        rollback   = 1'b0;
    endtask

    task automatic report_case(input int n, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("case %0d (%c) ok", n, case_op[n]);
        end else begin
            fail_count++;
            $display("case %0d (%c) failed", n, case_op[n]);
        end
    endtask

    // stimulus only, nothing to compare
    task automatic note_applied(input int n);
        $display("case %0d (%c) applied", n, case_op[n]);
    endtask

    task automatic compare_field(input int n, input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout int errs);
        if (got !== exp) begin
            $display("FAILED %0t: case %0d %s is %0h, expected %0h",
                     $time, n, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_rename(input int n);
        int errs;
        errs = 0;
        if (resp_valid !== 1'b1) begin
            $display("FAILED %0t: case %0d resp_valid is low", $time, n);
            errs++;
        end
        compare_field(n, "rd1", 32'(resp.rd1), case_arg[n][3], errs);
        compare_field(n, "rd2", 32'(resp.rd2), case_arg[n][4], errs);
        compare_field(n, "wr", 32'(resp.wr), case_arg[n][5], errs);
        compare_field(n, "oldwr", 32'(resp.oldwr), case_arg[n][6], errs);
        compare_field(n, "rd1_val", resp.rd1_val, case_arg[n][7], errs);
        compare_field(n, "rd2_val", resp.rd2_val, case_arg[n][8], errs);
        compare_field(n, "rd1_rdy", 32'(resp.rd1_rdy), case_arg[n][9], errs);
        compare_field(n, "rd2_rdy", 32'(resp.rd2_rdy), case_arg[n][10], errs);
        report_case(n, errs);
    endtask

    // a rename answers two falling edges after it was driven
    task automatic check_due();
        if (due_tick.size() > 0 && due_tick[0] == tick) begin
            check_rename(due_case.pop_front());
            void'(due_tick.pop_front());
        end else if (resp_valid === 1'b1) begin
            $display("resp_valid went high at %0t with no rename due", $time);
            fail_count++;
        end
    endtask

    task automatic drive_case(input int n);
        int errs;
        errs = 0;
        drive_idle();
        case (case_op[n])
            "R": begin
                uop_update = 1'b1;
                req.rd1    = rename_pkg::arch_idx_t'(case_arg[n][0]);
                req.rd2    = rename_pkg::arch_idx_t'(case_arg[n][1]);
                req.wr     = rename_pkg::arch_idx_t'(case_arg[n][2]);
                due_case.push_back(n);
                due_tick.push_back(tick + 2);
            end
            "W": begin
                wb_update = 1'b1;
                wb.phys   = rename_pkg::phys_idx_t'(case_arg[n][0]);
                wb.val    = case_arg[n][1];
                note_applied(n);
            end
            "C": begin
                rob_update          = 1'b1;
                commit.arch         = rename_pkg::arch_idx_t'(case_arg[n][0]);
                commit.nonspec_phys = rename_pkg::phys_idx_t'(case_arg[n][1]);
                commit.free_phys    = rename_pkg::phys_idx_t'(case_arg[n][2]);
                note_applied(n);
            end
            "B": begin
                // optional commit in the same cycle
                rollback            = 1'b1;
                rob_update          = case_arg[n][0][0];
                commit.arch         = rename_pkg::arch_idx_t'(case_arg[n][1]);
                commit.nonspec_phys = rename_pkg::phys_idx_t'(case_arg[n][2]);
                commit.free_phys    = rename_pkg::phys_idx_t'(case_arg[n][3]);
                note_applied(n);
            end
            default: begin
                if (none_free !== case_arg[n][0][0]) begin
                    $display("FAILED %0t: case %0d none_free is %b, expected %b",
                             $time, n, none_free, case_arg[n][0][0]);
                    errs++;
                end
                report_case(n, errs);
            end
        endcase
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        load_cases();
        limit = 4 * num_cases + 50;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < num_cases; n++) begin
            @(negedge clk);
            tick++;
            check_due();
            drive_case(n);
        end
        while (due_case.size() > 0) begin
            @(negedge clk);
            tick++;
            drive_idle();
            check_due();
        end
        $display("cases passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sim/rename_cases.txt
# R rd1 rd2 wr, expected rd1 rd2 wr oldwr rd1_val rd2_val rd1_rdy rd2_rdy (values in hex)
# W phys val | C arch nonspec_phys free_phys | B commit arch nonspec_phys free_phys | N none_free
R 1 2 3   1 2 32 3    00000000 00000000 1 1
R 3 4 5   32 4 33 5   00000000 00000000 0 1
R 6 7 6   6 7 34 6    00000000 00000000 1 1
W 32 deadbeef
W 33 12345678
R 3 5 8   32 33 35 8  deadbeef 12345678 1 1
R 0 0 10  0 0 36 10   00000000 00000000 1 1
R 0 0 10  0 0 37 36   00000000 00000000 1 1
R 0 0 10  0 0 38 37   00000000 00000000 1 1
R 0 0 10  0 0 39 38   00000000 00000000 1 1
R 0 0 10  0 0 40 39   00000000 00000000 1 1
R 0 0 10  0 0 41 40   00000000 00000000 1 1
R 0 0 10  0 0 42 41   00000000 00000000 1 1
R 0 0 10  0 0 43 42   00000000 00000000 1 1
R 0 0 10  0 0 44 43   00000000 00000000 1 1
R 0 0 10  0 0 45 44   00000000 00000000 1 1
R 0 0 10  0 0 46 45   00000000 00000000 1 1
R 0 0 10  0 0 47 46   00000000 00000000 1 1
R 0 0 10  0 0 48 47   00000000 00000000 1 1
R 0 0 10  0 0 49 48   00000000 00000000 1 1
R 0 0 10  0 0 50 49   00000000 00000000 1 1
R 0 0 10  0 0 51 50   00000000 00000000 1 1
R 0 0 10  0 0 52 51   00000000 00000000 1 1
R 0 0 10  0 0 53 52   00000000 00000000 1 1
R 0 0 10  0 0 54 53   00000000 00000000 1 1
R 0 0 10  0 0 55 54   00000000 00000000 1 1
R 0 0 10  0 0 56 55   00000000 00000000 1 1
R 0 0 10  0 0 57 56   00000000 00000000 1 1
R 0 0 10  0 0 58 57   00000000 00000000 1 1
R 0 0 10  0 0 59 58   00000000 00000000 1 1
R 0 0 10  0 0 60 59   00000000 00000000 1 1
R 0 0 10  0 0 61 60   00000000 00000000 1 1
R 0 0 10  0 0 62 61   00000000 00000000 1 1
R 0 0 10  0 0 63 62   00000000 00000000 1 1
N 1
C 3 32 3
N 0
R 0 0 11  0 0 3 11    00000000 00000000 1 1
N 1
C 5 33 5
B 0 0 0 0
R 0 0 3   0 0 3 32    00000000 00000000 1 1
R 0 0 5   0 0 5 33    00000000 00000000 1 1
R 6 8 10  6 8 34 10   00000000 00000000 1 1
R 0 0 7   0 0 35 7    00000000 00000000 1 1
B 1 7 35 7
R 7 3 7   35 32 3 35  00000000 deadbeef 0 1
R 0 0 10  0 0 5 10    00000000 00000000 1 1
N 0

//--- sources.f
verilog/rename_pkg.sv
verilog/arch_regfile.sv
verilog/free_list.sv
verilog/phys_file.sv
verilog/phys_regfile.sv
verilog/rename_regfile.sv
sim/tb_rename_regfile.sv

//--- Makefile
# Verilator build and run for the rename register file testbench

VERILATOR ?= verilator
TOP       ?= tb_rename_regfile
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
